// ==== hdl/sobelPixelPkg.sv ====
package sobelPixelPkg;

    // Camera pixel
    parameter int pixelWidth = 8;
    typedef logic [pixelWidth-1:0] pixel_t;

    // Signed gradient up to 1020 in magnitude
    parameter int gradWidth = 12;
    typedef logic signed [gradWidth-1:0] gradient_t;

    // Edge flags packed per output word
    parameter int wordWidth = 32;
    typedef logic [wordWidth-1:0] edgeWord_t;

    // Saturating count of lines since vsync
    typedef enum logic [1:0] {
        rowFirst,
        rowSecond,
        rowFull
    } rowPhase_e;

endpackage

// ==== hdl/sobelCiPkg.sv ====
package sobelCiPkg;

    // Operands and result of the custom instruction
    typedef logic [31:0] ciWord_t;

    // Instruction number
    typedef logic [7:0] ciNum_t;

    // Edge threshold register
    parameter int thresholdWidth = 16;
    typedef logic [thresholdWidth-1:0] threshold_t;

    // Field positions within value A
    parameter int ciWriteBit = 9;
    parameter int ciOpLsb = 10;

    // Register select where every other value reads as zero
    typedef enum logic [2:0] {
        opThreshold = 3'b100
    } ciOpcode_e;

endpackage

// ==== hdl/gradientIf.sv ====
`timescale 1ns/1ps

interface gradientIf #(
    parameter int colWidth = 8
);
    import sobelPixelPkg::*;

    // Registered gradients of the newest window
    gradient_t gx;
    gradient_t gy;
    // One cycle per accepted pixel
    logic gradValid;
    // Column of the newest pixel
    logic [colWidth-1:0] colIndex;

    modport source(output gx, output gy, output gradValid, output colIndex);
    modport sink(input gx, input gy, input gradValid, input colIndex);

endinterface

// ==== hdl/ciDecoder.sv ====
`timescale 1ns/1ps

module ciDecoder #(
    parameter sobelCiPkg::ciNum_t customId = '0
) (
    input  logic                   camClock,
    input  logic                   rstN,
    input  logic                   ciStart,
    input  sobelCiPkg::ciNum_t     ciN,
    input  sobelCiPkg::ciWord_t    ciValueA,
    input  sobelCiPkg::ciWord_t    ciValueB,
    output sobelCiPkg::ciWord_t    ciResult,
    output logic                   ciDone,
    output sobelCiPkg::threshold_t threshold
);
    import sobelCiPkg::*;

    logic validInstr;
    logic isWrite;
    logic [$bits(ciOpcode_e)-1:0] opField;

    // Only our instruction number counts
    assign validInstr = ciStart && (ciN == customId);
    assign ciDone = validInstr;

    assign isWrite = ciValueA[ciWriteBit];
    assign opField = ciValueA[ciOpLsb +: $bits(ciOpcode_e)];

    // Threshold write visible from the next edge
    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            threshold <= '0;
        end else if (validInstr && isWrite && opField == opThreshold) begin
            threshold <= ciValueB[thresholdWidth-1:0];
        end
    end

    // Readback in the same cycle as ciStart
    always_comb begin
        ciResult = '0;
        if (validInstr && !isWrite && opField == opThreshold) begin
            // zero-extended
            ciResult = ciWord_t'(threshold);
        end
    end

    // Instruction fields known whenever a start is presented
    knownFields: assert property (
        @(posedge camClock) disable iff (!rstN)
        ciStart |-> !$isunknown({ciN, ciValueA})
    );

endmodule

// ==== hdl/sobelWindow.sv ====
`timescale 1ns/1ps

module sobelWindow #(
    parameter int maxLineWidth = 256,
    localparam int colWidth = $clog2(maxLineWidth)
) (
    input  logic                  camClock,
    input  logic                  rstN,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  validCamera,
    input  sobelPixelPkg::pixel_t camData,
    gradientIf.source             grad
);
    import sobelPixelPkg::*;

    // Column of the incoming pixel
    logic [colWidth-1:0] colCount;
    rowPhase_e rowPhase;

    // Two previous lines with the newer one just above
    pixel_t olderLine [maxLineWidth];
    pixel_t newerLine [maxLineWidth];

    // Window columns with index 0 at the top and 2 at the bottom
    pixel_t [2:0] leftCol;
    pixel_t [2:0] midCol;
    pixel_t [2:0] rightCol;

    // Weighted column and row sums
    gradient_t sumLeft;
    gradient_t sumRight;
    gradient_t sumTop;
    gradient_t sumBottom;
    logic windowFull;

    // 1-2-1 weighting of zero-extended pixels
    function automatic gradient_t weightedSum(pixel_t a, pixel_t b, pixel_t c);
        return gradient_t'(a) + gradient_t'({b, 1'b0}) + gradient_t'(c);
    endfunction

    // Live right column with the two buffered lines above the incoming pixel
    assign rightCol = {camData, newerLine[colCount], olderLine[colCount]};

    // Need three lines and three columns
    assign windowFull = (rowPhase == rowFull) && (colCount >= colWidth'(2));

    always_comb begin
        sumLeft = weightedSum(leftCol[0], leftCol[1], leftCol[2]);
        sumRight = weightedSum(rightCol[0], rightCol[1], rightCol[2]);
        sumTop = weightedSum(leftCol[0], midCol[0], rightCol[0]);
        sumBottom = weightedSum(leftCol[2], midCol[2], rightCol[2]);
    end

    // Column and row tracking
    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            colCount <= '0;
            rowPhase <= rowFirst;
            grad.gradValid <= 1'b0;
        end else begin
            grad.gradValid <= validCamera;
            if (vsync) begin
                colCount <= '0;
                rowPhase <= rowFirst;
            end else if (hsync) begin
                colCount <= '0;
                // Saturates at rowFull
                if (rowPhase == rowFirst) begin
                    rowPhase <= rowSecond;
                end else begin
                    rowPhase <= rowFull;
                end
            end else if (validCamera) begin
                colCount <= colCount + 1'b1;
            end
        end
    end

    // Line buffers, window shift and gradient registers
    always_ff @(posedge camClock) begin
        if (validCamera) begin
            // Rotate at this column so the newer line ages and the new pixel enters
            olderLine[colCount] <= newerLine[colCount];
            newerLine[colCount] <= camData;

            leftCol <= midCol;
            midCol <= rightCol;

            grad.colIndex <= colCount;
            if (windowFull) begin
                // Right minus left
                grad.gx <= sumRight - sumLeft;
                // Top minus bottom
                grad.gy <= sumTop - sumBottom;
            end else begin
                grad.gx <= '0;
                grad.gy <= '0;
            end
        end
    end

    // Sync pulses only in blanking
    syncInBlanking: assert property (
        @(posedge camClock) disable iff (!rstN)
        validCamera |-> !(hsync || vsync)
    );

    // Line longer than the buffers
    colInRange: assert property (
        @(posedge camClock) disable iff (!rstN)
        colCount < maxLineWidth
    );

endmodule

// ==== hdl/edgePacker.sv ====
`timescale 1ns/1ps

module edgePacker #(
    parameter int maxLineWidth = 256,
    localparam int colWidth = $clog2(maxLineWidth),
    localparam int wordBits = $clog2(sobelPixelPkg::wordWidth)
) (
    input  logic                      camClock,
    input  logic                      rstN,
    gradientIf.sink                   grad,
    input  sobelCiPkg::threshold_t    threshold,
    output sobelPixelPkg::edgeWord_t  edgeWord,
    output logic                      wordValid,
    output logic [colWidth-wordBits-1:0] wordIndex
);
    import sobelPixelPkg::*;
    import sobelCiPkg::*;

    logic [gradWidth-1:0] absGx;
    logic [gradWidth-1:0] absGy;
    logic [thresholdWidth-1:0] magnitude;
    logic edgeBit;
    logic lastInWord;
    edgeWord_t shiftReg;
    edgeWord_t nextShift;

    // |gx| + |gy| reaching at most 2040
    assign absGx = grad.gx[gradWidth-1] ? -grad.gx : grad.gx;
    assign absGy = grad.gy[gradWidth-1] ? -grad.gy : grad.gy;
    assign magnitude = thresholdWidth'(absGx) + thresholdWidth'(absGy);

    // Strictly above threshold
    assign edgeBit = magnitude > threshold;

    // New bit at the LSB so the first pixel of a word ends in bit 31
    assign nextShift = {shiftReg[wordWidth-2:0], edgeBit};

    // Column 31 of each group of 32
    assign lastInWord = &grad.colIndex[wordBits-1:0];

    always_ff @(posedge camClock) begin
        if (grad.gradValid) begin
            shiftReg <= nextShift;
        end
        if (grad.gradValid && lastInWord) begin
            edgeWord <= nextShift;
            wordIndex <= grad.colIndex[colWidth-1:wordBits];
        end
    end

    // Word strobe that a partial word never reaches
    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= grad.gradValid && lastInWord;
        end
    end

    // At most one word per 32 pixels
    singleStrobe: assert property (
        @(posedge camClock) disable iff (!rstN)
        wordValid |=> !wordValid
    );

endmodule

// ==== hdl/sobelEdgeTop.sv ====
`timescale 1ns/1ps

module sobelEdgeTop #(
    parameter sobelCiPkg::ciNum_t customId = '0,
    parameter int maxLineWidth = 256,
    localparam int colWidth = $clog2(maxLineWidth),
    localparam int wordBits = $clog2(sobelPixelPkg::wordWidth)
) (
    input  logic                         camClock,
    input  logic                         rstN,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic                         validCamera,
    input  sobelPixelPkg::pixel_t        camData,
    input  logic                         ciStart,
    input  sobelCiPkg::ciNum_t           ciN,
    input  sobelCiPkg::ciWord_t          ciValueA,
    input  sobelCiPkg::ciWord_t          ciValueB,
    output sobelCiPkg::ciWord_t          ciResult,
    output logic                         ciDone,
    output sobelPixelPkg::edgeWord_t     edgeWord,
    output logic                         wordValid,
    output logic [colWidth-wordBits-1:0] wordIndex
);
    import sobelCiPkg::*;

    // Software threshold into the compare
    threshold_t threshold;

    // Gradients from window to packer
    gradientIf #(.colWidth(colWidth)) gradBus ();

    // Config port
    ciDecoder #(.customId(customId)) decoder (
        .camClock  (camClock),
        .rstN      (rstN),
        .ciStart   (ciStart),
        .ciN       (ciN),
        .ciValueA  (ciValueA),
        .ciValueB  (ciValueB),
        .ciResult  (ciResult),
        .ciDone    (ciDone),
        .threshold (threshold)
    );

    // Line buffers and Sobel gradients
    sobelWindow #(.maxLineWidth(maxLineWidth)) window (
        .camClock    (camClock),
        .rstN        (rstN),
        .hsync       (hsync),
        .vsync       (vsync),
        .validCamera (validCamera),
        .camData     (camData),
        .grad        (gradBus.source)
    );

    // Threshold and 32-bit packing
    edgePacker #(.maxLineWidth(maxLineWidth)) packer (
        .camClock  (camClock),
        .rstN      (rstN),
        .grad      (gradBus.sink),
        .threshold (threshold),
        .edgeWord  (edgeWord),
        .wordValid (wordValid),
        .wordIndex (wordIndex)
    );

endmodule

// ==== test/tbSobelEdge.sv ====
`timescale 1ns/1ps

module tbSobelEdge;

    localparam logic [7:0] ciId = 8'd5;
    localparam int lineWidth = 64;
    localparam int wordIdxWidth = $clog2(lineWidth) - 5;
    // Opcode 3'b100 in bits 12..10 and write flag in bit 9
    localparam logic [31:0] readThreshold = 32'h0000_1000;
    localparam logic [31:0] writeThreshold = 32'h0000_1200;

    logic camClock = 1'b0;
    logic rstN;
    logic hsync;
    logic vsync;
    logic validCamera;
    logic [7:0] camData;
    logic ciStart;
    logic [7:0] ciN;
    logic [31:0] ciValueA;
    logic [31:0] ciValueB;
    logic [31:0] ciResult;
    logic ciDone;
    logic [31:0] edgeWord;
    logic wordValid;
    logic [wordIdxWidth-1:0] wordIndex;

    // Parsed records with E records also in the expected queues
    logic [7:0] codeQ[$];
    int argA[$];
    int argB[$];
    int argC[$];
    int expIndex[$];
    logic [31:0] expWord[$];
    int errorCount = 0;
    int checkCount = 0;
    logic loadDone = 1'b0;

    sobelEdgeTop #(.customId(ciId), .maxLineWidth(lineWidth)) uut (
        .camClock(camClock), .rstN(rstN), .hsync(hsync), .vsync(vsync),
        .validCamera(validCamera), .camData(camData), .ciStart(ciStart),
        .ciN(ciN), .ciValueA(ciValueA), .ciValueB(ciValueB),
        .ciResult(ciResult), .ciDone(ciDone), .edgeWord(edgeWord),
        .wordValid(wordValid), .wordIndex(wordIndex)
    );

    always #4 camClock = ~camClock;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic loadVectors();
        int fd;
        int n;
        int a;
        int b;
        int c;
        logic [7:0] code;
        logic [7:0] kind;
        logic [31:0] w;
        logic [8*160-1:0] rest;
        fd = $fopen("test/sobelVectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/sobelVectors.txt, no vectors were run");
            errorCount++;
            return;
        end
        while ($fscanf(fd, " %c", code) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            case (code)
                "#": n = $fgets(rest, fd);
                "T", "R": n = $fscanf(fd, " %d", a);
                "N": n = $fscanf(fd, " %d %d", a, b);
                "V", "H": ;
                "L": begin
                    n = $fscanf(fd, " %c", kind);
                    if (kind == "C") begin
                        // Constant line as a step that never comes
                        n = $fscanf(fd, " %d", b);
                        a = lineWidth;
                        c = b;
                    end else begin
                        n = $fscanf(fd, " %d %d %d", a, b, c);
                    end
                end
                "E": begin
                    n = $fscanf(fd, " %d %h", a, w);
                    expIndex.push_back(a);
                    expWord.push_back(w);
                end
                default: begin
                    $display("Unknown record code %c in the vectors file", code);
                    errorCount++;
                end
            endcase
            if (code != "#") begin
                codeQ.push_back(code);
                argA.push_back(a);
                argB.push_back(b);
                argC.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // One instruction cycle and then one idle cycle with ciDone low
    task automatic runInstr(input logic [7:0] num, input logic [31:0] valueA,
                            input logic [31:0] valueB, input logic expDone,
                            input logic [31:0] expResult);
        @(posedge camClock);
        #1;
        ciStart = 1'b1;
        ciN = num;
        ciValueA = valueA;
        ciValueB = valueB;
        @(negedge camClock);
        checkValue("ciDone", {31'd0, expDone}, {31'd0, ciDone});
        checkValue("ciResult", expResult, ciResult);
        @(posedge camClock);
        #1;
        ciStart = 1'b0;
        @(negedge camClock);
        checkValue("ciDone", 32'd0, {31'd0, ciDone});
    endtask

    task automatic syncPulse(input logic isVsync);
        @(posedge camClock);
        #1;
        vsync = isVsync;
        hsync = !isVsync;
        @(posedge camClock);
        #1;
        vsync = 1'b0;
        hsync = 1'b0;
    endtask

    // Pixels below stepCol take low and the rest high
    task automatic sendLine(input int stepCol, input int low, input int high);
        for (int col = 0; col < lineWidth; col++) begin
            @(posedge camClock);
            #1;
            validCamera = 1'b1;
            camData = (col < stepCol) ? 8'(low) : 8'(high);
        end
        @(posedge camClock);
        #1;
        validCamera = 1'b0;
        // Blanking lets the last word drain
        repeat (4) @(posedge camClock);
    endtask

    // Words compared in arrival order
    always @(negedge camClock) begin
        if (rstN && wordValid) begin
            if (expWord.size() == 0) begin
                $display("Edge word at %0t ns arrived when no more words were expected", $time);
                errorCount++;
            end else begin
                checkValue("wordIndex", 32'(expIndex.pop_front()), 32'(wordIndex));
                checkValue("edgeWord", expWord.pop_front(), edgeWord);
            end
        end
    end

    initial begin
        rstN = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        validCamera = 1'b0;
        camData = '0;
        ciStart = 1'b0;
        ciN = '0;
        ciValueA = '0;
        ciValueB = '0;
        loadVectors();
        loadDone = 1'b1;
        repeat (4) @(posedge camClock);
        #1;
        rstN = 1'b1;
        foreach (codeQ[i]) begin
            case (codeQ[i])
                "T": runInstr(ciId, writeThreshold, argA[i], 1'b1, 32'd0);
                "R": runInstr(ciId, readThreshold, 32'd0, 1'b1, argA[i]);
                "N": runInstr(8'(argA[i]), writeThreshold, argB[i], 1'b0, 32'd0);
                "V": syncPulse(1'b1);
                "H": syncPulse(1'b0);
                "L": sendLine(argA[i], argB[i], argC[i]);
                default: ;
            endcase
        end
        repeat (10) @(posedge camClock);
        if (expWord.size() != 0) begin
            $display("%0d expected edge words never arrived", expWord.size());
            errorCount++;
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of 80 cycles per record plus slack
    initial begin
        wait (loadDone);
        #((codeQ.size() * 80 + 1000) * 8);
        $display("Run timed out before all records were processed");
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/sobelPixelPkg.sv
hdl/sobelCiPkg.sv
hdl/gradientIf.sv
hdl/ciDecoder.sv
hdl/sobelWindow.sv
hdl/edgePacker.sv
hdl/sobelEdgeTop.sv
test/tbSobelEdge.sv

// ==== test/sobelVectors.txt ====
# Codes: T thr | R expectedThr | N ciN value | V | H | L C pixel | L S col low high
# E wordIndex edgeWord, all fields decimal except the edge word in hex, E in output order
R 0
T 300
R 300
N 6 999
R 300
V
L C 100
E 0 00000000
E 1 00000000
H
L C 100
E 0 00000000
E 1 00000000
H
L C 100
E 0 00000000
E 1 00000000
V
L S 40 0 200
E 0 00000000
E 1 00000000
H
L S 40 0 200
E 0 00000000
E 1 00000000
H
L S 40 0 200
E 0 00000000
E 1 00c00000
T 800
R 800
H
L S 40 0 200
E 0 00000000
E 1 00000000
T 300
H
L S 40 0 200
E 0 00000000
E 1 00c00000
V
L S 40 0 200
E 0 00000000
E 1 00000000
H
L S 40 0 200
E 0 00000000
E 1 00000000
H
L S 40 0 200
E 0 00000000
E 1 00c00000
